//--- hw/fir_capture.sv
`timescale 1ns/1ps

module fir_capture import fir_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // input stream
  input  logic                sample_valid_i,
  input  logic [SAMPLE_W-1:0] sample_i,
  output logic                sample_ready_o,
  // injection from register block
  input  logic                inj_arm_i,
  input  logic [SAMPLE_W-1:0] inj_sample_i,
  // high during history clear
  input  logic                hold_i,
  // towards engine
  output logic                cap_valid_o,
  output logic [SAMPLE_W-1:0] cap_sample_o,
  input  logic                cap_ready_i
);

  logic                full_q;
  logic                arm_q;
  logic [SAMPLE_W-1:0] data_q;
  logic                accept;

  // one slot, only refilled once empty
  assign sample_ready_o = ~full_q & ~hold_i;
  assign accept         = sample_valid_i & sample_ready_o;

  assign cap_valid_o  = full_q;
  assign cap_sample_o = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      full_q <= 1'b0;
      arm_q  <= 1'b0;
    end else begin
      // accept only happens while empty
      if (accept) begin
        full_q <= 1'b1;
      end else if (cap_ready_i) begin
        full_q <= 1'b0;
      end
      // arm consumed by the next accepted sample
      // a fresh arm pulse wins over consumption
      if (inj_arm_i) begin
        arm_q <= 1'b1;
      end else if (accept) begin
        arm_q <= 1'b0;
      end
    end
  end

  // held sample, swapped for the injected value when armed
  always_ff @(posedge clk_i) begin
    if (accept) begin
      if (arm_q) begin
        data_q <= inj_sample_i;
      end else begin
        data_q <= sample_i;
      end
    end
  end

endmodule

//--- hw/fir_coeff_mem.sv
`timescale 1ns/1ps

module fir_coeff_mem import fir_pkg::*; (
  input  logic               clk_i,
  input  logic               rst_ni,
  // write from register block
  input  fir_coeff_wr_t      wr_i,
  // bus readback port
  input  logic [TAP_W-1:0]   bus_rd_idx_i,
  output logic [COEFF_W-1:0] bus_rd_data_o,
  // engine tap port
  input  fir_tap_rd_t        tap_rd_i,
  output logic [COEFF_W-1:0] tap_coeff_o
);

  logic [COEFF_W-1:0] coeff_q [NUM_TAPS];

  // coefficients come up as zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_TAPS; i++) begin
        coeff_q[i] <= '0;
      end
    end else if (wr_i.en) begin
      coeff_q[wr_i.idx] <= wr_i.value;
    end
  end

  // bus port reads every cycle
  // reg block picks it up one cycle after the request
  always_ff @(posedge clk_i) begin
    bus_rd_data_o <= coeff_q[bus_rd_idx_i];
  end

  // tap port, same latency as the sample ring
  always_ff @(posedge clk_i) begin
    if (tap_rd_i.en) begin
      tap_coeff_o <= coeff_q[tap_rd_i.idx];
    end
  end

endmodule

//--- hw/fir_mac_engine.sv
`timescale 1ns/1ps

module fir_mac_engine import fir_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // from capture stage
  input  logic                cap_valid_i,
  input  logic [SAMPLE_W-1:0] cap_sample_i,
  output logic                cap_ready_o,
  // ring write
  output logic                ring_wr_en_o,
  output logic [SAMPLE_W-1:0] ring_wr_sample_o,
  // tap reads to ring and coeff store
  output fir_tap_rd_t         tap_rd_o,
  input  logic [SAMPLE_W-1:0] tap_sample_i,
  input  logic [COEFF_W-1:0]  tap_coeff_i,
  // to result stage
  output logic                res_valid_o,
  output logic [OUT_W-1:0]    res_y_o,
  input  logic                res_ready_i
);

  localparam int unsigned PROD_W = SAMPLE_W + COEFF_W;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_WRITE,
    ST_ACCUM,
    ST_DRAIN,
    ST_HOLD
  } state_e;

  state_e              state_q;
  logic [TAP_W-1:0]    tap_idx_q;
  logic                data_vld_q;
  logic [ACC_W-1:0]    acc_q;
  logic [SAMPLE_W-1:0] sample_q;
  logic [PROD_W-1:0]   prod;
  logic [ACC_W-1:0]    prod_ext;

  // signed product, sign extended to the accumulator
  assign prod     = PROD_W'($signed(tap_sample_i) * $signed(tap_coeff_i));
  assign prod_ext = {{(ACC_W - PROD_W){prod[PROD_W-1]}}, prod};

  assign cap_ready_o      = (state_q == ST_IDLE);
  // new sample goes in before the first tap read
  assign ring_wr_en_o     = (state_q == ST_WRITE);
  assign ring_wr_sample_o = sample_q;

  assign tap_rd_o.en  = (state_q == ST_ACCUM);
  assign tap_rd_o.idx = tap_idx_q;

  // arithmetic shift right by 16, low 24 bits kept
  assign res_valid_o = (state_q == ST_HOLD);
  assign res_y_o     = acc_q[ACC_W-1:ACC_W-OUT_W];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= ST_IDLE;
      tap_idx_q  <= '0;
      data_vld_q <= 1'b0;
      acc_q      <= '0;
    end else begin
      // read data lands one cycle after the request
      data_vld_q <= tap_rd_o.en;
      if (data_vld_q) begin
        acc_q <= acc_q + prod_ext;
      end
      case (state_q)
        ST_IDLE: begin
          if (cap_valid_i) begin
            state_q <= ST_WRITE;
          end
        end
        ST_WRITE: begin
          acc_q     <= '0;
          tap_idx_q <= '0;
          state_q   <= ST_ACCUM;
        end
        ST_ACCUM: begin
          tap_idx_q <= tap_idx_q + TAP_W'(1);
          if (tap_idx_q == TAP_W'(NUM_TAPS - 1)) begin
            state_q <= ST_DRAIN;
          end
        end
        // last product still on its way
        ST_DRAIN: begin
          state_q <= ST_HOLD;
        end
        // stall here under back-pressure
        ST_HOLD: begin
          if (res_ready_i) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // sample taken on the capture handshake
  always_ff @(posedge clk_i) begin
    if (cap_valid_i && cap_ready_o) begin
      sample_q <= cap_sample_i;
    end
  end

endmodule

//--- hw/fir_pkg.sv
package fir_pkg;

  // filter geometry
  localparam int unsigned NUM_TAPS = 8;
  localparam int unsigned TAP_W    = 3;

  // datapath widths, all signed
  localparam int unsigned SAMPLE_W = 16;
  localparam int unsigned COEFF_W  = 16;
  localparam int unsigned ACC_W    = 40;
  // output is acc[39:16]
  localparam int unsigned OUT_W    = 24;
  localparam int unsigned OUT_CNT_W = 16;

  // register bus
  localparam int unsigned REG_ADDR_W = 4;
  localparam int unsigned REG_DATA_W = 32;

  // word addresses
  localparam logic [REG_ADDR_W-1:0] ADDR_CTRL          = 4'd0;
  localparam logic [REG_ADDR_W-1:0] ADDR_SAMPLE_INJ    = 4'd1;
  localparam logic [REG_ADDR_W-1:0] ADDR_COEFF_WR      = 4'd2;
  localparam logic [REG_ADDR_W-1:0] ADDR_LAST_Y        = 4'd3;
  localparam logic [REG_ADDR_W-1:0] ADDR_OUT_COUNT     = 4'd4;
  // taps 0..7 read back at 8..15
  localparam logic [REG_ADDR_W-1:0] ADDR_COEFF_RD_BASE = 4'd8;

  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [REG_ADDR_W-1:0] addr;
    logic [REG_DATA_W-1:0] wdata;
  } fir_reg_req_t;

  typedef struct packed {
    logic                  valid;
    logic [REG_DATA_W-1:0] rdata;
  } fir_reg_rsp_t;

  // write word, view picked by address
  typedef union packed {
    struct packed {
      logic [12:0]        pad;
      logic [TAP_W-1:0]   idx;
      logic [COEFF_W-1:0] value;
    } coeff_wr;
    struct packed {
      logic [30:0] pad;
      logic        clear_history;
    } ctrl;
  } fir_reg_word_u;

  // shared by sample ring and coeff store
  typedef struct packed {
    logic             en;
    logic [TAP_W-1:0] idx;
  } fir_tap_rd_t;

  typedef struct packed {
    logic               en;
    logic [TAP_W-1:0]   idx;
    logic [COEFF_W-1:0] value;
  } fir_coeff_wr_t;

endpackage

//--- hw/fir_reg_block.sv
`timescale 1ns/1ps

module fir_reg_block import fir_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // register bus
  input  fir_reg_req_t         reg_req_i,
  output logic                 reg_ready_o,
  output fir_reg_rsp_t         reg_rsp_o,
  // history clear
  input  logic                 clear_busy_i,
  output logic                 clear_o,
  // sample injection
  output logic                 inj_arm_o,
  output logic [SAMPLE_W-1:0]  inj_sample_o,
  // coefficient store
  output fir_coeff_wr_t        coeff_wr_o,
  output logic [TAP_W-1:0]     coeff_rd_idx_o,
  input  logic [COEFF_W-1:0]   coeff_rd_data_i,
  // result status
  input  logic [OUT_W-1:0]     last_y_i,
  input  logic [OUT_CNT_W-1:0] out_count_i
);

  fir_reg_word_u         wword;
  logic                  accept;
  logic                  wr_acc;
  logic                  rd_acc;
  logic                  rsp_valid_q;
  logic                  coeff_sel_q;
  logic [REG_DATA_W-1:0] rdata_q;
  logic [REG_DATA_W-1:0] coeff_rd_ext;

  // stall the bus for the whole sweep
  assign reg_ready_o = ~clear_busy_i;
  assign accept      = reg_req_i.valid & reg_ready_o;
  assign wr_acc      = accept & reg_req_i.we;
  assign rd_acc      = accept & ~reg_req_i.we;

  assign wword = reg_req_i.wdata;

  // coeff store reads in the accept cycle
  assign coeff_rd_idx_o = reg_req_i.addr[TAP_W-1:0];
  assign coeff_rd_ext   = {{(REG_DATA_W - COEFF_W){coeff_rd_data_i[COEFF_W-1]}}, coeff_rd_data_i};

  assign reg_rsp_o = '{valid: rsp_valid_q, rdata: coeff_sel_q ? coeff_rd_ext : rdata_q};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q  <= 1'b0;
      coeff_sel_q  <= 1'b0;
      rdata_q      <= '0;
      clear_o      <= 1'b0;
      inj_arm_o    <= 1'b0;
      inj_sample_o <= '0;
      coeff_wr_o   <= '0;
    end else begin
      // one response per accepted request, reads and writes alike
      rsp_valid_q <= accept;
      coeff_sel_q <= rd_acc && (reg_req_i.addr >= ADDR_COEFF_RD_BASE);

      // write decode, ctrl view or coeff view by address
      clear_o          <= wr_acc && (reg_req_i.addr == ADDR_CTRL) && wword.ctrl.clear_history;
      inj_arm_o        <= wr_acc && (reg_req_i.addr == ADDR_SAMPLE_INJ);
      coeff_wr_o.en    <= wr_acc && (reg_req_i.addr == ADDR_COEFF_WR);
      coeff_wr_o.idx   <= wword.coeff_wr.idx;
      coeff_wr_o.value <= wword.coeff_wr.value;
      if (wr_acc && (reg_req_i.addr == ADDR_SAMPLE_INJ)) begin
        inj_sample_o <= reg_req_i.wdata[SAMPLE_W-1:0];
      end

      // status readback, zero for anything else
      if (rd_acc) begin
        case (reg_req_i.addr)
          ADDR_LAST_Y: begin
            rdata_q <= {{(REG_DATA_W - OUT_W){last_y_i[OUT_W-1]}}, last_y_i};
          end
          ADDR_OUT_COUNT: begin
            rdata_q <= REG_DATA_W'(out_count_i);
          end
          default: begin
            rdata_q <= '0;
          end
        endcase
      end
    end
  end

endmodule

//--- hw/fir_result_stage.sv
`timescale 1ns/1ps

module fir_result_stage import fir_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // from engine
  input  logic                 res_valid_i,
  input  logic [OUT_W-1:0]     res_y_i,
  output logic                 res_ready_o,
  // output stream
  output logic                 y_valid_o,
  output logic [OUT_W-1:0]     y_o,
  input  logic                 y_ready_i,
  // status for register block
  output logic [OUT_W-1:0]     last_y_o,
  output logic [OUT_CNT_W-1:0] out_count_o
);

  logic                 y_valid_q;
  logic [OUT_W-1:0]     y_q;
  logic [OUT_W-1:0]     last_y_q;
  logic [OUT_CNT_W-1:0] cnt_q;
  logic                 load;
  logic                 deliver;

  // empty, or drained in this same cycle
  assign res_ready_o = ~y_valid_q | y_ready_i;
  assign load        = res_valid_i & res_ready_o;
  assign deliver     = y_valid_q & y_ready_i;

  assign y_valid_o   = y_valid_q;
  assign y_o         = y_q;
  assign last_y_o    = last_y_q;
  assign out_count_o = cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      y_valid_q <= 1'b0;
      last_y_q  <= '0;
      cnt_q     <= '0;
    end else begin
      if (load) begin
        y_valid_q <= 1'b1;
      end else if (y_ready_i) begin
        y_valid_q <= 1'b0;
      end
      // status follows delivered outputs only
      if (deliver) begin
        last_y_q <= y_q;
        cnt_q    <= cnt_q + OUT_CNT_W'(1);
      end
    end
  end

  // stable while stalled
  always_ff @(posedge clk_i) begin
    if (load) begin
      y_q <= res_y_i;
    end
  end

endmodule

//--- hw/fir_sample_ring.sv
`timescale 1ns/1ps

module fir_sample_ring import fir_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                wr_en_i,
  input  logic [SAMPLE_W-1:0] wr_sample_i,
  input  logic                clear_i,
  output logic                clear_busy_o,
  input  fir_tap_rd_t         tap_rd_i,
  output logic [SAMPLE_W-1:0] tap_sample_o
);

  logic [SAMPLE_W-1:0] mem_q [NUM_TAPS];
  logic [TAP_W-1:0]    wr_ptr_q;
  logic [TAP_W-1:0]    rd_addr;
  logic                clr_busy_q;
  logic [TAP_W-1:0]    clr_cnt_q;
  logic                clr_act;

  // entry k steps back from the newest, wraps mod 8
  assign rd_addr = wr_ptr_q - TAP_W'(1) - tap_rd_i.idx;

  // sweep starts in the pulse cycle
  // counter rests at entry 0 between sweeps
  assign clr_act      = clear_i | clr_busy_q;
  assign clear_busy_o = clr_act;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q   <= '0;
      clr_busy_q <= 1'b0;
      clr_cnt_q  <= '0;
      for (int i = 0; i < NUM_TAPS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (wr_en_i) begin
        mem_q[wr_ptr_q] <= wr_sample_i;
        wr_ptr_q        <= wr_ptr_q + TAP_W'(1);
      end
      // sweep overrides a colliding sample write
      if (clr_act) begin
        mem_q[clr_cnt_q] <= '0;
      end
      if (clear_i) begin
        clr_busy_q <= 1'b1;
        clr_cnt_q  <= TAP_W'(1);
      end else if (clr_busy_q) begin
        clr_cnt_q <= clr_cnt_q + TAP_W'(1);
        if (clr_cnt_q == TAP_W'(NUM_TAPS - 1)) begin
          clr_busy_q <= 1'b0;
        end
      end
    end
  end

  // registered tap read, data one cycle after request
  always_ff @(posedge clk_i) begin
    if (tap_rd_i.en) begin
      tap_sample_o <= mem_q[rd_addr];
    end
  end

endmodule

//--- hw/fir_top.sv
`timescale 1ns/1ps

module fir_top import fir_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  // sample stream in
  input  logic                sample_valid_i,
  input  logic [SAMPLE_W-1:0] sample_i,
  output logic                sample_ready_o,
  // result stream out
  output logic                y_valid_o,
  output logic [OUT_W-1:0]    y_o,
  input  logic                y_ready_i,
  // register bus
  input  fir_reg_req_t        reg_req_i,
  output logic                reg_ready_o,
  output fir_reg_rsp_t        reg_rsp_o
);

  logic                 cap_valid;
  logic                 cap_ready;
  logic [SAMPLE_W-1:0]  cap_sample;
  logic                 inj_arm;
  logic [SAMPLE_W-1:0]  inj_sample;
  logic                 clear;
  logic                 clear_busy;
  logic                 ring_wr_en;
  logic [SAMPLE_W-1:0]  ring_wr_sample;
  fir_tap_rd_t          tap_rd;
  logic [SAMPLE_W-1:0]  tap_sample;
  logic [COEFF_W-1:0]   tap_coeff;
  fir_coeff_wr_t        coeff_wr;
  logic [TAP_W-1:0]     coeff_rd_idx;
  logic [COEFF_W-1:0]   coeff_rd_data;
  logic                 res_valid;
  logic                 res_ready;
  logic [OUT_W-1:0]     res_y;
  logic [OUT_W-1:0]     last_y;
  logic [OUT_CNT_W-1:0] out_count;

  // capture held off while the history is cleared
  fir_capture i_capture (
    .clk_i, .rst_ni, .sample_valid_i, .sample_i, .sample_ready_o,
    .inj_arm_i(inj_arm), .inj_sample_i(inj_sample), .hold_i(clear_busy),
    .cap_valid_o(cap_valid), .cap_sample_o(cap_sample), .cap_ready_i(cap_ready)
  );

  fir_sample_ring i_ring (
    .clk_i, .rst_ni, .wr_en_i(ring_wr_en), .wr_sample_i(ring_wr_sample),
    .clear_i(clear), .clear_busy_o(clear_busy), .tap_rd_i(tap_rd), .tap_sample_o(tap_sample)
  );

  fir_coeff_mem i_coeff (
    .clk_i, .rst_ni, .wr_i(coeff_wr), .bus_rd_idx_i(coeff_rd_idx),
    .bus_rd_data_o(coeff_rd_data), .tap_rd_i(tap_rd), .tap_coeff_o(tap_coeff)
  );

  // one tap request feeds both stores
  fir_mac_engine i_engine (
    .clk_i, .rst_ni, .cap_valid_i(cap_valid), .cap_sample_i(cap_sample),
    .cap_ready_o(cap_ready), .ring_wr_en_o(ring_wr_en), .ring_wr_sample_o(ring_wr_sample),
    .tap_rd_o(tap_rd), .tap_sample_i(tap_sample), .tap_coeff_i(tap_coeff),
    .res_valid_o(res_valid), .res_y_o(res_y), .res_ready_i(res_ready)
  );

  fir_result_stage i_result (
    .clk_i, .rst_ni, .res_valid_i(res_valid), .res_y_i(res_y), .res_ready_o(res_ready),
    .y_valid_o, .y_o, .y_ready_i, .last_y_o(last_y), .out_count_o(out_count)
  );

  fir_reg_block i_regs (
    .clk_i, .rst_ni, .reg_req_i, .reg_ready_o, .reg_rsp_o,
    .clear_busy_i(clear_busy), .clear_o(clear), .inj_arm_o(inj_arm),
    .inj_sample_o(inj_sample), .coeff_wr_o(coeff_wr), .coeff_rd_idx_o(coeff_rd_idx),
    .coeff_rd_data_i(coeff_rd_data), .last_y_i(last_y), .out_count_i(out_count)
  );

endmodule

//--- project.f
+incdir+tb
hw/fir_pkg.sv
hw/fir_capture.sv
hw/fir_sample_ring.sv
hw/fir_coeff_mem.sv
hw/fir_mac_engine.sv
hw/fir_result_stage.sv
hw/fir_reg_block.sv
hw/fir_top.sv
tb/fir_tb.sv

//--- tb/fir_tb_model.svh
`ifndef FIR_TB_MODEL_SVH
`define FIR_TB_MODEL_SVH

// impulse in 0..7, random after that, history cleared before entry 40
localparam int NUM_ENTRIES = 48;
localparam int CLEAR_ENTRY = 40;

// taps 0..7, both signs and both extremes
logic [COEFF_W-1:0] coeff_set [NUM_TAPS] = '{
  16'h1000, 16'hf800, 16'h7fff, 16'h8000, 16'h0123, 16'hfedc, 16'h2000, 16'h0001
};

// model history, newest sample at index 0
logic signed [SAMPLE_W-1:0] hist [NUM_TAPS];

// stimulus and expected output per entry
logic [SAMPLE_W-1:0] tbl_sample  [NUM_ENTRIES];
logic                tbl_inject  [NUM_ENTRIES];
logic [SAMPLE_W-1:0] tbl_inj_val [NUM_ENTRIES];
logic [OUT_W-1:0]    tbl_exp     [NUM_ENTRIES];

function automatic void clear_model_history();
  for (int k = 0; k < NUM_TAPS; k++) begin
    hist[k] = '0;
  end
endfunction

// shift in one sample, full signed sum, then >>> 16 keeping 24 bits
function automatic logic [OUT_W-1:0] model_step(input logic [SAMPLE_W-1:0] x);
  logic signed [ACC_W-1:0] acc;
  acc = '0;
  for (int k = NUM_TAPS - 1; k > 0; k--) begin
    hist[k] = hist[k-1];
  end
  hist[0] = x;
  for (int k = 0; k < NUM_TAPS; k++) begin
    acc += $signed(hist[k]) * $signed(coeff_set[k]);
  end
  acc = acc >>> 16;
  return acc[OUT_W-1:0];
endfunction

function automatic void fill_table();
  logic [SAMPLE_W-1:0] used;
  clear_model_history();
  for (int i = 0; i < NUM_ENTRIES; i++) begin
    if (i == 0) begin
      tbl_sample[i] = 16'h4000;
    end else if (i < NUM_TAPS) begin
      tbl_sample[i] = '0;
    end else begin
      tbl_sample[i] = SAMPLE_W'($urandom);
    end
    // a few injected samples, one of them after the clear
    tbl_inject[i]  = (i >= NUM_TAPS) && (i % 7 == 3);
    tbl_inj_val[i] = SAMPLE_W'($urandom);
    if (i == CLEAR_ENTRY) begin
      clear_model_history();
    end
    used       = tbl_inject[i] ? tbl_inj_val[i] : tbl_sample[i];
    tbl_exp[i] = model_step(used);
  end
endfunction

`endif

//--- tb/fir_tb.sv
`timescale 1ns/1ps

module fir_tb import fir_pkg::*; ();

  logic                clk;
  logic                rst_n;
  logic                sample_valid;
  logic [SAMPLE_W-1:0] sample;
  logic                sample_ready;
  logic                y_valid;
  logic [OUT_W-1:0]    y;
  logic                y_ready;
  fir_reg_req_t        reg_req;
  logic                reg_ready;
  fir_reg_rsp_t        reg_rsp;

  `include "fir_tb_model.svh"

  localparam int TIMEOUT_CYCLES = 40 * NUM_ENTRIES + 500;

  int               errors;
  int               checks;
  int               n_out;
  int               cycle_cnt;
  logic [OUT_W-1:0] last_out;
  logic [OUT_W-1:0] exp_q [$];
  logic [31:0]      rdata;

  fir_top i_dut (
    .clk_i(clk), .rst_ni(rst_n),
    .sample_valid_i(sample_valid), .sample_i(sample), .sample_ready_o(sample_ready),
    .y_valid_o(y_valid), .y_o(y), .y_ready_i(y_ready),
    .reg_req_i(reg_req), .reg_ready_o(reg_ready), .reg_rsp_o(reg_rsp)
  );

  always #10 clk = ~clk;

  // random back-pressure, ready three times out of four
  task automatic drive_backpressure();
    forever begin
      @(posedge clk);
      y_ready <= (($urandom % 4) != 0);
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  // outputs checked in order, handshake completes on the next edge
  always @(negedge clk) begin
    if (rst_n && y_valid && y_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("output %h delivered with no sample pending", y);
      end else begin
        check(32'(y), 32'(exp_q.pop_front()), "filter output");
      end
      n_out++;
      last_out = y;
    end
  end

  task automatic reg_access(input logic we, input logic [REG_ADDR_W-1:0] addr,
                            input logic [REG_DATA_W-1:0] wdata,
                            output logic [REG_DATA_W-1:0] data);
    @(posedge clk);
    reg_req <= '{valid: 1'b1, we: we, addr: addr, wdata: wdata};
    @(negedge clk);
    while (!reg_ready) @(negedge clk);
    // accepted on this edge
    @(posedge clk);
    reg_req.valid <= 1'b0;
    @(negedge clk);
    check(32'(reg_rsp.valid), 32'd1, "register response valid");
    data = reg_rsp.rdata;
    // response lasts a single cycle
    @(negedge clk);
    check(32'(reg_rsp.valid), 32'd0, "register response valid for one cycle only");
  endtask

  task automatic reg_write(input logic [REG_ADDR_W-1:0] addr, input logic [REG_DATA_W-1:0] wdata);
    logic [REG_DATA_W-1:0] unused;
    reg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_read_check(input logic [REG_ADDR_W-1:0] addr,
                                input logic [REG_DATA_W-1:0] exp, input string what);
    reg_access(1'b0, addr, '0, rdata);
    check(rdata, exp, what);
  endtask

  // returns on the acceptance edge
  task automatic send_sample(input logic [SAMPLE_W-1:0] value, input logic [OUT_W-1:0] exp);
    @(posedge clk);
    sample_valid <= 1'b1;
    sample       <= value;
    @(negedge clk);
    while (!sample_ready) @(negedge clk);
    @(posedge clk);
    sample_valid <= 1'b0;
    exp_q.push_back(exp);
  endtask

  task automatic wait_drained();
    @(negedge clk);
    while (exp_q.size() != 0) @(negedge clk);
  endtask

  initial begin
    void'($urandom(32'h3a1331c9));
    clk          = 1'b0;
    rst_n        = 1'b0;
    sample_valid = 1'b0;
    sample       = '0;
    y_ready      = 1'b0;
    reg_req      = '0;
    errors       = 0;
    checks       = 0;
    n_out        = 0;
    cycle_cnt    = 0;
    last_out     = '0;
    fill_table();
    // back-pressure runs for the rest of the test
    fork
      drive_backpressure();
    join_none
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;

    // idle state and zeroed registers after reset
    @(negedge clk);
    check(32'(y_valid), 32'd0, "y_valid after reset");
    check(32'(sample_ready), 32'd1, "sample_ready after reset");
    check(32'(reg_rsp.valid), 32'd0, "response valid after reset");
    reg_read_check(ADDR_LAST_Y, '0, "LAST_Y after reset");
    reg_read_check(ADDR_OUT_COUNT, '0, "OUT_COUNT after reset");
    for (int k = 0; k < NUM_TAPS; k++) begin
      reg_read_check(REG_ADDR_W'(ADDR_COEFF_RD_BASE + k), '0, $sformatf("coeff %0d after reset", k));
    end

    // coefficient write and sign-extended readback
    for (int k = 0; k < NUM_TAPS; k++) begin
      reg_write(ADDR_COEFF_WR, {13'h0, TAP_W'(k), coeff_set[k]});
    end
    for (int k = 0; k < NUM_TAPS; k++) begin
      reg_read_check(REG_ADDR_W'(ADDR_COEFF_RD_BASE + k),
                     REG_DATA_W'($signed(coeff_set[k])),
                     $sformatf("coeff %0d readback", k));
    end

    // impulse, random samples, injections and a history clear
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (i == CLEAR_ENTRY) begin
        wait_drained();
        reg_write(ADDR_CTRL, 32'h1);
        check(32'(reg_ready), 32'd0, "bus stalled during clear");
        check(32'(sample_ready), 32'd0, "stream stalled during clear");
      end
      if (tbl_inject[i]) begin
        reg_write(ADDR_SAMPLE_INJ, {16'h0, tbl_inj_val[i]});
      end
      send_sample(tbl_sample[i], tbl_exp[i]);
    end
    wait_drained();

    // status registers against what was delivered
    check(32'(n_out), 32'(NUM_ENTRIES), "number of outputs");
    check(32'(last_out), 32'(tbl_exp[NUM_ENTRIES-1]), "last output");
    reg_read_check(ADDR_OUT_COUNT, 32'(NUM_ENTRIES), "OUT_COUNT at end");
    reg_read_check(ADDR_LAST_Y, REG_DATA_W'($signed(tbl_exp[NUM_ENTRIES-1])),
                   "LAST_Y at end");

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
